/* hdl/lift_config.svh */
`ifndef LIFT_CONFIG_SVH
`define LIFT_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// Sizes of the shared RAM port
////////////////////////////////////////////////////////////////////////

`define LIFT_DATA_W 240 // One coefficient word
`define LIFT_ADDR_W 9 // 0 to 511, MSB picks the core half
`define LIFT_MSEL_W 4

////////////////////////////////////////////////////////////////////////
// Transfer schedule
////////////////////////////////////////////////////////////////////////

`define LIFT_BURST_LEN 8 // Words per block
`define LIFT_BLOCKS_PER_CORE 4
`define LIFT_STAGGER_CYCLES 16 // Core 0 start to core 1 start

`endif

/* hdl/lift_pkg.sv */
`include "lift_config.svh"

package lift_pkg;

    ////////////////////////////////////////////////////////////////////
    // Core and port types
    ////////////////////////////////////////////////////////////////////

    // Core index, also the address MSB of that core's half
    typedef logic [0:0] core_id_t;

    // One access on the shared block RAM port
    typedef struct packed {
        logic [`LIFT_ADDR_W-1:0] addr;
        logic                    we; // High for a write, low for a read
        logic [`LIFT_MSEL_W-1:0] mem_sel; // Read or write memory
        logic [`LIFT_DATA_W-1:0] wdata;
    } bram_port_t;

    // Port value with no write and a zero address
    localparam bram_port_t BRAM_PORT_IDLE = '0;

endpackage

/* hdl/lift_core_ctrl.sv */
`timescale 1ns/1ps
`include "lift_config.svh"

module lift_core_ctrl #(
    parameter int CORE_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    core_start,
    input  logic [`LIFT_MSEL_W-1:0] mem_rd_sel,
    input  logic [`LIFT_MSEL_W-1:0] mem_wr_sel,
    input  logic [`LIFT_DATA_W-1:0] bram_rdata,
    input  logic                    bram_gnt,
    output logic                    bram_req,
    output lift_pkg::bram_port_t    bram_out,
    output logic                    core_done
);
    import lift_pkg::*;

    localparam int WORD_W = $clog2(`LIFT_BURST_LEN);
    localparam int BLK_W  = $clog2(`LIFT_BLOCKS_PER_CORE);
    localparam int PAD_W  = `LIFT_ADDR_W - 1 - BLK_W - WORD_W; // Unused middle bits
    localparam core_id_t MY_ID = core_id_t'(CORE_ID);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_BURST,
        S_RD_TAIL,
        S_WR_REQ,
        S_WR_BURST,
        S_DONE
    } state_t;

    state_t                  state;
    logic [WORD_W-1:0]       word_cnt;
    logic [BLK_W-1:0]        block_cnt;
    logic                    hold_off; // Drops the request for one cycle
    logic                    last_word;
    logic                    last_block;
    logic [`LIFT_ADDR_W-1:0] word_addr;

    // Read capture, one cycle behind the address
    logic                    rd_valid_q;
    logic [WORD_W-1:0]       rd_idx_q;
    logic [`LIFT_DATA_W-1:0] word_buf [`LIFT_BURST_LEN];

    assign last_word  = (word_cnt == WORD_W'(`LIFT_BURST_LEN - 1));
    assign last_block = (block_cnt == BLK_W'(`LIFT_BLOCKS_PER_CORE - 1));

    // Core half, then block and word
    assign word_addr = {MY_ID, {PAD_W{1'b0}}, block_cnt, word_cnt};

    ////////////////////////////////////////////////////////////////////
    // Block scheduler
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            word_cnt  <= '0;
            block_cnt <= '0;
            hold_off  <= 1'b0;
        end else begin
            hold_off <= 1'b0;
            case (state)
                S_IDLE, S_DONE: begin
                    if (core_start) begin
                        state     <= S_RD_REQ;
                        word_cnt  <= '0;
                        block_cnt <= '0;
                    end
                end
                S_RD_REQ: begin
                    if (bram_gnt && !hold_off) begin
                        state <= S_RD_BURST;
                    end
                end
                S_RD_BURST: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        word_cnt <= '0;
                        state    <= S_RD_TAIL;
                    end
                end
                S_RD_TAIL: begin // Last read word lands here
                    state    <= S_WR_REQ;
                    hold_off <= 1'b1; // Let the other core in
                end
                S_WR_REQ: begin
                    if (bram_gnt && !hold_off) begin
                        state <= S_WR_BURST;
                    end
                end
                S_WR_BURST: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        word_cnt <= '0;
                        if (last_block) begin
                            state <= S_DONE;
                        end else begin
                            block_cnt <= block_cnt + 1'b1;
                            state     <= S_RD_REQ;
                            hold_off  <= 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Request and port drive
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        bram_req = 1'b0;
        bram_out = BRAM_PORT_IDLE;
        case (state)
            S_RD_REQ, S_WR_REQ: begin
                bram_req = !hold_off;
            end
            S_RD_BURST: begin
                bram_req         = 1'b1;
                bram_out.addr    = word_addr;
                bram_out.mem_sel = mem_rd_sel;
            end
            S_RD_TAIL: begin
                bram_req = 1'b1; // Keep the grant for the last capture
            end
            S_WR_BURST: begin
                bram_req         = 1'b1;
                bram_out.addr    = word_addr;
                bram_out.we      = 1'b1;
                bram_out.mem_sel = mem_wr_sel;
                bram_out.wdata   = word_buf[word_cnt]; // Result is the buffered word
            end
            default: begin
                bram_req = 1'b0;
            end
        endcase
    end

    assign core_done = (state == S_DONE);

    ////////////////////////////////////////////////////////////////////
    // Word buffer
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (state == S_RD_BURST);
        end
    end

    always_ff @(posedge clk) begin
        rd_idx_q <= word_cnt;
        if (rd_valid_q) begin
            word_buf[rd_idx_q] <= bram_rdata;
        end
    end

    // Any address on the port or data in flight needs this core's grant
    assert property (@(posedge clk) disable iff (rst)
        (bram_out.we || state == S_RD_BURST || rd_valid_q) |-> bram_gnt)
        else $error("core %0d used the RAM port without a grant", CORE_ID);

endmodule

/* hdl/lift_core_sequencer.sv */
`timescale 1ns/1ps
`include "lift_config.svh"

module lift_core_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [1:0] core_done,
    output logic [1:0] core_start,
    output logic       done
);

    localparam int CNT_W = $clog2(`LIFT_STAGGER_CYCLES);

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_START0,
        SQ_STAGGER,
        SQ_START1,
        SQ_WAIT_BOTH,
        SQ_DONE
    } seq_state_t;

    seq_state_t       state;
    logic [CNT_W-1:0] stagger_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SQ_IDLE;
            stagger_cnt <= '0;
        end else begin
            case (state)
                SQ_IDLE, SQ_DONE: begin
                    if (start) state <= SQ_START0; // Only accepted when not busy
                end
                SQ_START0: begin
                    stagger_cnt <= '0;
                    state       <= SQ_STAGGER;
                end
                SQ_STAGGER: begin
                    stagger_cnt <= stagger_cnt + 1'b1;
                    // START0 and START1 count as the two ends of the stagger
                    if (stagger_cnt == CNT_W'(`LIFT_STAGGER_CYCLES - 2)) begin
                        state <= SQ_START1;
                    end
                end
                SQ_START1:    state <= SQ_WAIT_BOTH;
                SQ_WAIT_BOTH: if (&core_done) state <= SQ_DONE;
                default:      state <= SQ_IDLE;
            endcase
        end
    end

    assign core_start[0] = (state == SQ_START0);
    assign core_start[1] = (state == SQ_START1);
    assign done          = (state == SQ_DONE); // Held until the next start

    for (genvar i = 0; i < 2; i++) begin : g_pulse_chk
        assert property (@(posedge clk) disable iff (rst)
            core_start[i] |=> !core_start[i])
            else $error("core_start[%0d] held longer than one cycle", i);
    end

    // Fixed gap between the two core starts
    assert property (@(posedge clk) disable iff (rst)
        core_start[0] |-> ##(`LIFT_STAGGER_CYCLES) core_start[1])
        else $error("core 1 start not on the stagger cycle");

endmodule

/* hdl/lift_bram_arbiter.sv */
`timescale 1ns/1ps

module lift_bram_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [1:0]                 bram_req,
    input  lift_pkg::bram_port_t [1:0] core_port,
    output logic [1:0]                 bram_gnt,
    output lift_pkg::bram_port_t       bram_port
);
    import lift_pkg::*;

    logic [1:0] gnt_next;
    core_id_t   gnt_id;

    ////////////////////////////////////////////////////////////////////
    // Grant register
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        if (bram_gnt[0] && bram_req[0]) begin
            gnt_next = 2'b01; // Holder keeps it
        end else if (bram_gnt[1] && bram_req[1]) begin
            gnt_next = 2'b10;
        end else if (bram_req[0]) begin
            gnt_next = 2'b01; // Core 0 wins a tie
        end else if (bram_req[1]) begin
            gnt_next = 2'b10;
        end else begin
            gnt_next = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bram_gnt <= 2'b00;
        end else begin
            bram_gnt <= gnt_next;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Port multiplexer
    ////////////////////////////////////////////////////////////////////

    assign gnt_id = core_id_t'(bram_gnt[1]);

    // Idle port keeps we low when nobody holds the grant
    assign bram_port = (|bram_gnt) ? core_port[gnt_id] : BRAM_PORT_IDLE;

    assert property (@(posedge clk) disable iff (rst) $onehot0(bram_gnt))
        else $error("both cores granted the RAM port");

endmodule

/* hdl/lift_control_top.sv */
`timescale 1ns/1ps
`include "lift_config.svh"

module lift_control_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`LIFT_MSEL_W-1:0] mem_rd_sel,
    input  logic [`LIFT_MSEL_W-1:0] mem_wr_sel,
    input  logic [`LIFT_DATA_W-1:0] bram_rdata,
    output lift_pkg::bram_port_t    bram_port,
    output logic                    done
);
    import lift_pkg::*;

    logic [1:0]       core_start;
    logic [1:0]       core_done;
    logic [1:0]       bram_req;
    logic [1:0]       bram_gnt;
    bram_port_t [1:0] core_port; // One request struct per core

    lift_core_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .core_done  (core_done),
        .core_start (core_start),
        .done       (done)
    );

    // Core 0 works on the lower address half
    lift_core_ctrl #(.CORE_ID(0)) core0_i (
        .clk        (clk),
        .rst        (rst),
        .core_start (core_start[0]),
        .mem_rd_sel (mem_rd_sel),
        .mem_wr_sel (mem_wr_sel),
        .bram_rdata (bram_rdata),
        .bram_gnt   (bram_gnt[0]),
        .bram_req   (bram_req[0]),
        .bram_out   (core_port[0]),
        .core_done  (core_done[0])
    );

    lift_core_ctrl #(.CORE_ID(1)) core1_i (
        .clk        (clk),
        .rst        (rst),
        .core_start (core_start[1]),
        .mem_rd_sel (mem_rd_sel),
        .mem_wr_sel (mem_wr_sel),
        .bram_rdata (bram_rdata), // Shared read data, only the granted core captures
        .bram_gnt   (bram_gnt[1]),
        .bram_req   (bram_req[1]),
        .bram_out   (core_port[1]),
        .core_done  (core_done[1])
    );

    lift_bram_arbiter arb_i (
        .clk       (clk),
        .rst       (rst),
        .bram_req  (bram_req),
        .core_port (core_port),
        .bram_gnt  (bram_gnt),
        .bram_port (bram_port)
    );

endmodule

/* testbench/tb_bram_model.sv */
`timescale 1ns/1ps
`include "lift_config.svh"

module tb_bram_model (
    input  logic                    clk,
    input  lift_pkg::bram_port_t    port,
    input  logic [`LIFT_MSEL_W-1:0] rd_sel, // Selects the run expects
    input  logic [`LIFT_MSEL_W-1:0] wr_sel,
    input  logic                    clear_stats,
    input  logic                    load_en,
    input  logic [`LIFT_MSEL_W-1:0] load_sel,
    input  logic [`LIFT_ADDR_W-1:0] load_addr,
    input  logic [`LIFT_DATA_W-1:0] load_data,
    output logic [`LIFT_DATA_W-1:0] rdata
);

    localparam int MEMS  = 1 << `LIFT_MSEL_W;
    localparam int WORDS = 1 << `LIFT_ADDR_W;

    logic [`LIFT_DATA_W-1:0] mem [MEMS][WORDS];
    int unsigned             wr_count [WORDS]; // Writes on wr_sel per address
    int unsigned             bad_sel_cnt;

    always_ff @(posedge clk) begin
        rdata <= mem[port.mem_sel][port.addr]; // Data one cycle after the address
        if (clear_stats) begin
            for (int a = 0; a < WORDS; a++) begin
                wr_count[a] <= 0;
            end
            bad_sel_cnt <= 0;
        end else if (port.we) begin
            if (port.mem_sel == wr_sel) begin
                wr_count[port.addr] <= wr_count[port.addr] + 1;
            end else begin
                bad_sel_cnt <= bad_sel_cnt + 1;
            end
        end else if (port.mem_sel != '0 && port.mem_sel != rd_sel) begin
            // Select 0 is the idle port value and counts as no read
            bad_sel_cnt <= bad_sel_cnt + 1;
        end

        if (load_en) begin
            mem[load_sel][load_addr] <= load_data;
        end else if (port.we) begin
            mem[port.mem_sel][port.addr] <= port.wdata;
        end
    end

endmodule

/* testbench/tb_lift_control.sv */
`timescale 1ns/1ps
`include "lift_config.svh"

module tb_lift_control;
    import lift_pkg::*;

    localparam int RUNS         = 2;
    localparam int RUN_CYCLES   = 2 * `LIFT_BLOCKS_PER_CORE * (4 * `LIFT_BURST_LEN + 8);
    localparam int WATCHDOG_NS  = RUNS * RUN_CYCLES * 20 * 4;
    localparam int REGION_WORDS = `LIFT_BLOCKS_PER_CORE * `LIFT_BURST_LEN;
    localparam int MEM_WORDS    = 1 << `LIFT_ADDR_W;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    start;
    logic [`LIFT_MSEL_W-1:0] mem_rd_sel;
    logic [`LIFT_MSEL_W-1:0] mem_wr_sel;
    logic [`LIFT_DATA_W-1:0] bram_rdata;
    bram_port_t              bram_port;
    logic                    done;

    // Preload and statistics control of the RAM model
    logic                    clear_stats;
    logic                    load_en;
    logic [`LIFT_MSEL_W-1:0] load_sel;
    logic [`LIFT_ADDR_W-1:0] load_addr;
    logic [`LIFT_DATA_W-1:0] load_data;

    logic [31:0]             lfsr;
    logic [`LIFT_DATA_W-1:0] exp_words [MEM_WORDS]; // Read data as loaded
    int                      error_cnt;
    int                      check_cnt;

    always #10 clk = ~clk;

    lift_control_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .mem_rd_sel (mem_rd_sel),
        .mem_wr_sel (mem_wr_sel),
        .bram_rdata (bram_rdata),
        .bram_port  (bram_port),
        .done       (done)
    );

    tb_bram_model bram_i (
        .clk         (clk),
        .port        (bram_port),
        .rd_sel      (mem_rd_sel),
        .wr_sel      (mem_wr_sel),
        .clear_stats (clear_stats),
        .load_en     (load_en),
        .load_sel    (load_sel),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .rdata       (bram_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic make_random_word(output logic [`LIFT_DATA_W-1:0] w);
        for (int i = 0; i < `LIFT_DATA_W; i++) begin
            lfsr = lfsr_next(lfsr); // One step per bit
            w[i] = lfsr[0];
        end
    endtask

    // Core half in the MSB with block and word below
    function automatic logic [`LIFT_ADDR_W-1:0] region_addr(input int core, input int idx);
        return `LIFT_ADDR_W'(core * (MEM_WORDS / 2) + idx);
    endfunction

    task automatic flag_error(input string msg);
        error_cnt++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    task automatic load_read_memory(input logic [`LIFT_MSEL_W-1:0] rd_sel);
        logic [`LIFT_DATA_W-1:0] w;
        logic [`LIFT_ADDR_W-1:0] a;
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < REGION_WORDS; i++) begin
                a = region_addr(c, i);
                make_random_word(w);
                exp_words[a] = w;
                @(posedge clk);
                #2;
                load_en   = 1'b1;
                load_sel  = rd_sel;
                load_addr = a;
                load_data = w;
            end
        end
        @(posedge clk);
        #2;
        load_en     = 1'b0;
        clear_stats = 1'b1;
        @(posedge clk);
        #2 clear_stats = 1'b0;
    endtask

    task automatic wait_done(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < RUN_CYCLES * 4) begin
            @(negedge clk);
            seen = (done === 1'b1);
            n++;
        end
        if (!seen) begin
            error_cnt++;
            $display("done did not rise within %0d cycles of the start", RUN_CYCLES * 4);
        end
    endtask

    // Waits for a write to one address on the RAM port
    task automatic wait_for_write(input logic [`LIFT_ADDR_W-1:0] addr, output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < RUN_CYCLES * 4) begin
            @(negedge clk);
            seen = (bram_port.we === 1'b1 && bram_port.addr === addr);
            n++;
        end
        if (!seen) begin
            error_cnt++;
            $display("no write to address %0d within %0d cycles of the start",
                     addr, RUN_CYCLES * 4);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_check();
        @(posedge clk);
        #2;
        rst   = 1'b1;
        start = 1'b0;
        @(posedge clk); // First edge that sees the reset
        repeat (2) begin
            @(negedge clk);
            check_cnt++;
            if (done !== 1'b0 || bram_port.we !== 1'b0) begin
                flag_error("done or write enable high during reset");
            end
        end
        @(posedge clk);
        #2 rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_cnt++;
            if (done !== 1'b0 || bram_port.we !== 1'b0) begin
                flag_error("done or write enable high just after reset");
            end
        end
    endtask

    // Write memory against loaded data, then write counts and selects
    task automatic check_memories(input logic [`LIFT_MSEL_W-1:0] wr_sel);
        logic [`LIFT_ADDR_W-1:0] a;
        bit                      in_region;
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < REGION_WORDS; i++) begin
                a = region_addr(c, i);
                check_cnt++;
                if (bram_i.mem[wr_sel][a] !== exp_words[a]) begin
                    flag_error($sformatf("result word at address %0d is wrong", a));
                end
            end
        end
        for (int x = 0; x < MEM_WORDS; x++) begin
            in_region = (x % (MEM_WORDS / 2)) < REGION_WORDS;
            check_cnt++;
            if (in_region && bram_i.wr_count[x] != 1) begin
                flag_error($sformatf("address %0d written %0d times, expected once",
                                     x, bram_i.wr_count[x]));
            end else if (!in_region && bram_i.wr_count[x] != 0) begin
                flag_error($sformatf("address %0d outside the core regions written", x));
            end
        end
        check_cnt++;
        if (bram_i.bad_sel_cnt != 0) begin
            flag_error($sformatf("%0d accesses used an unexpected memory select",
                                 bram_i.bad_sel_cnt));
        end
    endtask

    task automatic hold_check();
        repeat (50) begin
            @(negedge clk);
            check_cnt++;
            if (done !== 1'b1) flag_error("done dropped after the run ended");
            check_cnt++;
            if (bram_port.we !== 1'b0) flag_error("write enable high after done");
        end
    endtask

    task automatic run_test(input logic [`LIFT_MSEL_W-1:0] rd_sel,
                            input logic [`LIFT_MSEL_W-1:0] wr_sel,
                            input bit                      mid_start);
        bit seen;
        @(posedge clk);
        #2;
        mem_rd_sel = rd_sel;
        mem_wr_sel = wr_sel;
        load_read_memory(rd_sel);
        pulse_start();
        if (mid_start) begin
            // Core 0 ends its last block while core 1 still has blocks to move
            wait_for_write(region_addr(0, REGION_WORDS - 1), seen);
            check_cnt++;
            if (done !== 1'b0) flag_error("done high while core 1 was still busy");
            pulse_start(); // An accepted start would rerun core 0
        end
        wait_done(seen);
        if (seen) begin
            check_memories(wr_sel);
            hold_check();
        end
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        mem_rd_sel  = '0;
        mem_wr_sel  = '0;
        clear_stats = 1'b0;
        load_en     = 1'b0;
        load_sel    = '0;
        load_addr   = '0;
        load_data   = '0;
        lfsr        = 32'd77467;
        error_cnt   = 0;
        check_cnt   = 0;

        reset_check();
        run_test(`LIFT_MSEL_W'(3), `LIFT_MSEL_W'(5), 1'b1);
        reset_check();
        run_test(`LIFT_MSEL_W'(9), `LIFT_MSEL_W'(12), 1'b0); // Fresh data and selects

        $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the simulation did not end within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/lift_pkg.sv
hdl/lift_core_ctrl.sv
hdl/lift_core_sequencer.sv
hdl/lift_bram_arbiter.sv
hdl/lift_control_top.sv
testbench/tb_bram_model.sv
testbench/tb_lift_control.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the lift control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lift_control \
    -f filelist.f \
    -o sim_lift_control

./obj_dir/sim_lift_control | tee sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
